/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -f verilog.f --top-module tbSpiMaster -o simSpiMaster

output="$(./obj_dir/simSpiMaster)"
echo "$output"

if grep -q "ALL TESTS PASSED" <<< "$output"; then
  exit 0
else
  exit 1
fi

/* source/readWriteSPIWireData.sv */
`timescale 1ns/1ps

module readWriteSPIWireData (
  input  logic             clk_i,
  input  logic             rst_i,
  input  spiPkg::spiByte_t clkDelay_i,
  input  spiPkg::spiByte_t txData_i,
  input  logic             txDataFull_i,
  output logic             txDataFullClr_o,
  output spiPkg::spiByte_t rxData_o,
  output logic             rxDataRdySet_o,
  output logic             spiClkOut_o,
  output logic             spiDataOut_o,
  input  logic             spiDataIn_i
);
  import spiPkg::*;

  logic shifting;
  spiByte_t divCnt;
  logic [3:0] edgeCnt;
  spiByte_t txShift;
  spiByte_t rxShift;
  logic halfTick;

  // One SPI clock edge every clkDelay+1 cycles
  assign halfTick = shifting && (divCnt >= clkDelay_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      shifting <= 1'b0;
      divCnt <= '0;
      edgeCnt <= '0;
      txDataFullClr_o <= 1'b0;
      rxDataRdySet_o <= 1'b0;
      spiClkOut_o <= 1'b0;
      spiDataOut_o <= 1'b1;
    end else begin
      txDataFullClr_o <= 1'b0;
      rxDataRdySet_o <= 1'b0;
      if (!shifting) begin
        divCnt <= '0;
        edgeCnt <= '0;
        if (txDataFull_i && !txDataFullClr_o) begin
          // MSB goes out before the first rising edge
          shifting <= 1'b1;
          txDataFullClr_o <= 1'b1;
          spiDataOut_o <= txData_i[7];
        end
      end else if (halfTick) begin
        divCnt <= '0;
        edgeCnt <= edgeCnt + 4'd1;
        spiClkOut_o <= ~edgeCnt[0];
        if (edgeCnt == 4'd15) begin
          shifting <= 1'b0;
          rxDataRdySet_o <= 1'b1;
          spiDataOut_o <= 1'b1;
        end else if (edgeCnt[0]) begin
          spiDataOut_o <= txShift[6];
        end
      end else begin
        divCnt <= divCnt + 8'd1;
      end
    end
  end

  // Data path, sample on rising and shift on falling
  always_ff @(posedge clk_i) begin
    if (!shifting && txDataFull_i) begin
      txShift <= txData_i;
    end else if (halfTick && edgeCnt[0]) begin
      txShift <= {txShift[6:0], IDLE_BYTE[0]};
    end
    if (halfTick && !edgeCnt[0]) begin
      rxShift <= {rxShift[6:0], spiDataIn_i};
    end
    if (halfTick && edgeCnt == 4'd15) begin
      rxData_o <= rxShift;
    end
  end

endmodule

/* source/sendCmd.sv */
`timescale 1ns/1ps

module sendCmd (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             sendCmdReq_i,
  output logic             sendCmdRdy_o,
  input  spiPkg::spiByte_t cmdByte_i,
  input  logic [31:0]      cmdArg_i,
  output spiPkg::spiByte_t respByte_o,
  output logic             respTout_o,
  output spiPkg::spiByte_t txData_o,
  output logic             txDataWen_o,
  input  logic             txDataFull_i,
  input  spiPkg::spiByte_t rxData_i,
  input  logic             rxDataRdy_i,
  output logic             rxDataRdyClr_o
);
  import spiPkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND,
    ST_SEND_WAIT,
    ST_POLL,
    ST_POLL_WAIT
  } cmdState_t;

  cmdState_t state;
  logic [2:0] byteCnt;
  logic [3:0] pollCnt;
  logic [6:0] crc;
  spiByte_t curByte;

  // CRC7, polynomial x^7 + x^3 + 1, MSB first
  function automatic logic [6:0] crc7Byte(input logic [6:0] crcIn, input spiByte_t data);
    logic [6:0] c;
    logic fb;
    c = crcIn;
    for (int i = 7; i >= 0; i--) begin
      fb = c[6] ^ data[i];
      c = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return c;
  endfunction

  always_comb begin
    case (byteCnt)
      3'd0:    curByte = {2'b01, cmdByte_i[5:0]};
      3'd1:    curByte = cmdArg_i[31:24];
      3'd2:    curByte = cmdArg_i[23:16];
      3'd3:    curByte = cmdArg_i[15:8];
      3'd4:    curByte = cmdArg_i[7:0];
      default: curByte = {crc, 1'b1};
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state <= ST_IDLE;
      sendCmdRdy_o <= 1'b1;
      respTout_o <= 1'b0;
      txDataWen_o <= 1'b0;
      rxDataRdyClr_o <= 1'b0;
      byteCnt <= '0;
      pollCnt <= '0;
      crc <= '0;
    end else begin
      txDataWen_o <= 1'b0;
      rxDataRdyClr_o <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (sendCmdReq_i) begin
            sendCmdRdy_o <= 1'b0;
            respTout_o <= 1'b0;
            byteCnt <= '0;
            crc <= '0;
            state <= ST_SEND;
          end
        end
        ST_SEND: begin
          if (!txDataFull_i) begin
            txData_o <= curByte;
            txDataWen_o <= 1'b1;
            if (byteCnt != 3'd5) begin
              crc <= crc7Byte(crc, curByte);
            end
            state <= ST_SEND_WAIT;
          end
        end
        ST_SEND_WAIT: begin
          if (rxDataRdy_i) begin
            rxDataRdyClr_o <= 1'b1;
            pollCnt <= '0;
            byteCnt <= byteCnt + 3'd1;
            state <= (byteCnt == 3'd5) ? ST_POLL : ST_SEND;
          end
        end
        ST_POLL: begin
          if (!txDataFull_i) begin
            txData_o <= IDLE_BYTE;
            txDataWen_o <= 1'b1;
            state <= ST_POLL_WAIT;
          end
        end
        ST_POLL_WAIT: begin
          if (rxDataRdy_i) begin
            rxDataRdyClr_o <= 1'b1;
            pollCnt <= pollCnt + 4'd1;
            // R1 starts with a zero bit
            if (!rxData_i[7]) begin
              respByte_o <= rxData_i;
              sendCmdRdy_o <= 1'b1;
              state <= ST_IDLE;
            end else if (pollCnt == 4'(RESP_TOUT_BYTES - 1)) begin
              respByte_o <= IDLE_BYTE;
              respTout_o <= 1'b1;
              sendCmdRdy_o <= 1'b1;
              state <= ST_IDLE;
            end else begin
              state <= ST_POLL;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* source/spiCtrl.sv */
`timescale 1ns/1ps

module spiCtrl (
  input  logic               clk_i,
  input  logic               rst_i,
  input  spiPkg::transType_t transType_i,
  input  logic               start_i,
  input  spiPkg::spiByte_t   directTxData_i,
  output logic               busy_o,
  output logic               spiCS_n_o,
  output logic               sendCmdReq_o,
  input  logic               sendCmdRdy_i,
  output spiPkg::spiByte_t   txData_o,
  output logic               txDataWen_o,
  input  logic               txDataFull_i,
  input  logic               rxDataRdy_i,
  output logic               rxDataRdyClr_o
);
  import spiPkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_BYTE_WR,
    ST_BYTE_WAIT,
    ST_CMD_REQ,
    ST_CMD_WAIT
  } ctrlState_t;

  ctrlState_t state;
  logic [3:0] byteCnt;
  logic isInit;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state <= ST_IDLE;
      byteCnt <= '0;
      isInit <= 1'b0;
      busy_o <= 1'b0;
      spiCS_n_o <= 1'b1;
      sendCmdReq_o <= 1'b0;
      txDataWen_o <= 1'b0;
      rxDataRdyClr_o <= 1'b0;
    end else begin
      sendCmdReq_o <= 1'b0;
      txDataWen_o <= 1'b0;
      rxDataRdyClr_o <= 1'b0;
      case (state)
        ST_IDLE: begin
          byteCnt <= '0;
          if (start_i) begin
            case (transType_i)
              TRANS_INIT: begin
                // Card wake-up clocks with CS deasserted
                busy_o <= 1'b1;
                isInit <= 1'b1;
                txData_o <= IDLE_BYTE;
                state <= ST_BYTE_WR;
              end
              TRANS_DIRECT: begin
                busy_o <= 1'b1;
                isInit <= 1'b0;
                spiCS_n_o <= 1'b0;
                txData_o <= directTxData_i;
                state <= ST_BYTE_WR;
              end
              TRANS_CMD: begin
                busy_o <= 1'b1;
                spiCS_n_o <= 1'b0;
                state <= ST_CMD_REQ;
              end
              default: ;
            endcase
          end
        end
        ST_BYTE_WR: begin
          if (!txDataFull_i) begin
            txDataWen_o <= 1'b1;
            state <= ST_BYTE_WAIT;
          end
        end
        ST_BYTE_WAIT: begin
          if (rxDataRdy_i) begin
            rxDataRdyClr_o <= 1'b1;
            byteCnt <= byteCnt + 4'd1;
            if (!isInit || byteCnt == 4'(INIT_BYTES - 1)) begin
              busy_o <= 1'b0;
              spiCS_n_o <= 1'b1;
              state <= ST_IDLE;
            end else begin
              state <= ST_BYTE_WR;
            end
          end
        end
        ST_CMD_REQ: begin
          sendCmdReq_o <= 1'b1;
          state <= ST_CMD_WAIT;
        end
        ST_CMD_WAIT: begin
          // Ready is still high in the cycle the request is out
          if (sendCmdRdy_i && !sendCmdReq_o) begin
            busy_o <= 1'b0;
            spiCS_n_o <= 1'b1;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* source/spiMaster.sv */
`timescale 1ns/1ps

module spiMaster (
  input  logic             clk_i,
  input  logic             rst_i,
  input  spiPkg::regAddr_t address_i,
  input  spiPkg::busWord_t data_i,
  output spiPkg::busWord_t data_o,
  input  logic             select_i,
  input  logic             we_i,
  output logic             spiClkOut_o,
  input  logic             spiDataIn_i,
  output logic             spiDataOut_o,
  output logic             spiCS_n_o
);
  import spiPkg::*;

  transType_t transType;
  logic startStrobe;
  logic busy;
  logic sdInit;
  spiByte_t directTxData;
  spiByte_t clkDelayFromRegs;
  spiByte_t spiClkDelay;
  spiByte_t cmdByte;
  logic [31:0] cmdArg;
  spiByte_t respByte;
  logic respTout;
  logic sendCmdReq;
  logic sendCmdRdy;
  logic spiCS_nFromSpiCtrl;
  spiByte_t txDataFromSpiCtrl;
  logic txDataWenFromSpiCtrl;
  logic rxDataRdyClrFromSpiCtrl;
  spiByte_t txDataFromSendCmd;
  logic txDataWenFromSendCmd;
  logic rxDataRdyClrFromSendCmd;
  spiByte_t txDataToWire;
  logic txDataFull;
  logic txDataFullClr;
  spiByte_t rxDataFromWire;
  logic rxDataRdySet;
  spiByte_t rxData;
  logic rxDataRdy;

  // CS is also held low while the command sender is active
  assign spiCS_n_o = spiCS_nFromSpiCtrl & sendCmdRdy;
  assign spiClkDelay = sdInit ? SLOW_SPI_CLK_DELAY : clkDelayFromRegs;

  spiMasterRegs u_spiMasterRegs (
    .clk_i(clk_i), .rst_i(rst_i),
    .address_i(address_i), .data_i(data_i), .data_o(data_o),
    .select_i(select_i), .we_i(we_i),
    .busy_i(busy), .respByte_i(respByte), .respTout_i(respTout),
    .rxData_i(rxData),
    .transType_o(transType), .start_o(startStrobe),
    .txData_o(directTxData), .clkDelay_o(clkDelayFromRegs),
    .cmdByte_o(cmdByte), .cmdArg_o(cmdArg), .sdInit_o(sdInit)
  );

  spiCtrl u_spiCtrl (
    .clk_i(clk_i), .rst_i(rst_i),
    .transType_i(transType), .start_i(startStrobe),
    .directTxData_i(directTxData), .busy_o(busy),
    .spiCS_n_o(spiCS_nFromSpiCtrl),
    .sendCmdReq_o(sendCmdReq), .sendCmdRdy_i(sendCmdRdy),
    .txData_o(txDataFromSpiCtrl), .txDataWen_o(txDataWenFromSpiCtrl),
    .txDataFull_i(txDataFull), .rxDataRdy_i(rxDataRdy),
    .rxDataRdyClr_o(rxDataRdyClrFromSpiCtrl)
  );

  sendCmd u_sendCmd (
    .clk_i(clk_i), .rst_i(rst_i),
    .sendCmdReq_i(sendCmdReq), .sendCmdRdy_o(sendCmdRdy),
    .cmdByte_i(cmdByte), .cmdArg_i(cmdArg),
    .respByte_o(respByte), .respTout_o(respTout),
    .txData_o(txDataFromSendCmd), .txDataWen_o(txDataWenFromSendCmd),
    .txDataFull_i(txDataFull), .rxData_i(rxData), .rxDataRdy_i(rxDataRdy),
    .rxDataRdyClr_o(rxDataRdyClrFromSendCmd)
  );

  // Third requester slot is free for a block transfer engine
  spiTxRxData u_spiTxRxData (
    .clk_i(clk_i), .rst_i(rst_i),
    .tx1Data_i(txDataFromSendCmd), .tx1Wen_i(txDataWenFromSendCmd),
    .tx2Data_i(txDataFromSpiCtrl), .tx2Wen_i(txDataWenFromSpiCtrl),
    .tx3Data_i(IDLE_BYTE), .tx3Wen_i(1'b0),
    .txDataOut_o(txDataToWire), .txDataFull_o(txDataFull),
    .txDataFullClr_i(txDataFullClr),
    .rxData_i(rxDataFromWire), .rxDataRdySet_i(rxDataRdySet),
    .rxDataOut_o(rxData), .rxDataRdy_o(rxDataRdy),
    .rx1Clr_i(rxDataRdyClrFromSendCmd), .rx2Clr_i(rxDataRdyClrFromSpiCtrl),
    .rx3Clr_i(1'b0)
  );

  readWriteSPIWireData u_readWriteSPIWireData (
    .clk_i(clk_i), .rst_i(rst_i),
    .clkDelay_i(spiClkDelay),
    .txData_i(txDataToWire), .txDataFull_i(txDataFull),
    .txDataFullClr_o(txDataFullClr),
    .rxData_o(rxDataFromWire), .rxDataRdySet_o(rxDataRdySet),
    .spiClkOut_o(spiClkOut_o), .spiDataOut_o(spiDataOut_o),
    .spiDataIn_i(spiDataIn_i)
  );

endmodule

/* source/spiMasterRegs.sv */
`timescale 1ns/1ps

module spiMasterRegs (
  input  logic               clk_i,
  input  logic               rst_i,
  input  spiPkg::regAddr_t   address_i,
  input  spiPkg::busWord_t   data_i,
  output spiPkg::busWord_t   data_o,
  input  logic               select_i,
  input  logic               we_i,
  input  logic               busy_i,
  input  spiPkg::spiByte_t   respByte_i,
  input  logic               respTout_i,
  input  spiPkg::spiByte_t   rxData_i,
  output spiPkg::transType_t transType_o,
  output logic               start_o,
  output spiPkg::spiByte_t   txData_o,
  output spiPkg::spiByte_t   clkDelay_o,
  output spiPkg::spiByte_t   cmdByte_o,
  output logic [31:0]        cmdArg_o,
  output logic               sdInit_o
);
  import spiPkg::*;

  logic writeEn;
  logic [15:0] argHi;
  logic [15:0] argLo;

  assign writeEn = select_i & we_i;
  assign cmdArg_o = {argHi, argLo};

  // Init runs from the start pulse until busy drops
  assign sdInit_o = (transType_o == TRANS_INIT) & (busy_i | start_o);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      transType_o <= TRANS_NONE;
      start_o <= 1'b0;
      clkDelay_o <= 8'd1;
    end else begin
      start_o <= 1'b0;
      if (writeEn && address_i == REG_CTRL && !busy_i && !start_o) begin
        transType_o <= transType_t'(data_i[1:0]);
        start_o <= 1'b1;
      end
      if (writeEn && address_i == REG_CLKDELAY) begin
        clkDelay_o <= data_i[7:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (writeEn) begin
      case (address_i)
        REG_TXDATA: txData_o <= data_i[7:0];
        REG_CMD:    cmdByte_o <= data_i[7:0];
        REG_ARGHI:  argHi <= data_i[15:0];
        REG_ARGLO:  argLo <= data_i[15:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    data_o = '0;
    if (select_i) begin
      case (address_i)
        REG_CTRL:     data_o = {16'd0, respTout_i, busy_i};
        REG_TXDATA:   data_o = {10'd0, txData_o};
        REG_RXDATA:   data_o = {10'd0, rxData_i};
        REG_CLKDELAY: data_o = {10'd0, clkDelay_o};
        REG_CMD:      data_o = {10'd0, cmdByte_o};
        REG_ARGHI:    data_o = {2'd0, argHi};
        REG_ARGLO:    data_o = {2'd0, argLo};
        REG_RESP:     data_o = {10'd0, respByte_i};
        default:      data_o = '0;
      endcase
    end
  end

endmodule

/* source/spiPkg.sv */
package spiPkg;

  typedef logic [7:0] spiByte_t;
  typedef logic [17:0] busWord_t;
  typedef logic [2:0] regAddr_t;

  typedef enum logic [1:0] {
    TRANS_NONE,
    TRANS_INIT,
    TRANS_DIRECT,
    TRANS_CMD
  } transType_t;

  // Bus register map
  localparam regAddr_t REG_CTRL     = 3'd0;
  localparam regAddr_t REG_TXDATA   = 3'd1;
  localparam regAddr_t REG_RXDATA   = 3'd2;
  localparam regAddr_t REG_CLKDELAY = 3'd3;
  localparam regAddr_t REG_CMD      = 3'd4;
  localparam regAddr_t REG_ARGHI    = 3'd5;
  localparam regAddr_t REG_ARGLO    = 3'd6;
  localparam regAddr_t REG_RESP     = 3'd7;

  // SD card in SPI mode
  localparam spiByte_t SLOW_SPI_CLK_DELAY = 8'd16;
  localparam int unsigned INIT_BYTES = 10;
  localparam int unsigned RESP_TOUT_BYTES = 8;
  localparam spiByte_t IDLE_BYTE = 8'hFF;

endpackage

/* source/spiTxRxData.sv */
`timescale 1ns/1ps

module spiTxRxData (
  input  logic             clk_i,
  input  logic             rst_i,
  input  spiPkg::spiByte_t tx1Data_i,
  input  logic             tx1Wen_i,
  input  spiPkg::spiByte_t tx2Data_i,
  input  logic             tx2Wen_i,
  input  spiPkg::spiByte_t tx3Data_i,
  input  logic             tx3Wen_i,
  output spiPkg::spiByte_t txDataOut_o,
  output logic             txDataFull_o,
  input  logic             txDataFullClr_i,
  input  spiPkg::spiByte_t rxData_i,
  input  logic             rxDataRdySet_i,
  output spiPkg::spiByte_t rxDataOut_o,
  output logic             rxDataRdy_o,
  input  logic             rx1Clr_i,
  input  logic             rx2Clr_i,
  input  logic             rx3Clr_i
);

  // Fixed priority, writer 1 first
  always_ff @(posedge clk_i) begin
    if (tx1Wen_i) begin
      txDataOut_o <= tx1Data_i;
    end else if (tx2Wen_i) begin
      txDataOut_o <= tx2Data_i;
    end else if (tx3Wen_i) begin
      txDataOut_o <= tx3Data_i;
    end
    if (rxDataRdySet_i) begin
      rxDataOut_o <= rxData_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      txDataFull_o <= 1'b0;
      rxDataRdy_o <= 1'b0;
    end else begin
      if (tx1Wen_i || tx2Wen_i || tx3Wen_i) begin
        txDataFull_o <= 1'b1;
      end else if (txDataFullClr_i) begin
        txDataFull_o <= 1'b0;
      end
      if (rxDataRdySet_i) begin
        rxDataRdy_o <= 1'b1;
      end else if (rx1Clr_i || rx2Clr_i || rx3Clr_i) begin
        rxDataRdy_o <= 1'b0;
      end
    end
  end

endmodule

/* tb/sdCardModel.sv */
`timescale 1ns/1ps

module sdCardModel (
  input  logic             spiClk_i,
  input  logic             mosi_i,
  input  logic             csN_i,
  input  logic             clear_i,
  input  logic             respEn_i,
  input  spiPkg::spiByte_t respIdx_i,
  input  spiPkg::spiByte_t respVal_i,
  output logic             miso_o
);
  import spiPkg::*;

  int logCount;
  int csHighEdges;
  spiByte_t logMem [0:63];
  spiByte_t shiftIn;
  spiByte_t txByte;
  logic [2:0] bitCnt;

  // Reply byte only at the programmed byte slot
  assign txByte = (respEn_i && logCount == int'(respIdx_i)) ? respVal_i : IDLE_BYTE;
  assign miso_o = csN_i ? 1'b1 : txByte[3'd7 - bitCnt];

  always @(posedge spiClk_i or posedge clear_i) begin
    if (clear_i) begin
      logCount <= 0;
      csHighEdges <= 0;
      bitCnt <= 3'd0;
      shiftIn <= 8'h00;
    end else if (csN_i) begin
      csHighEdges <= csHighEdges + 1;
    end else begin
      shiftIn <= {shiftIn[6:0], mosi_i};
      bitCnt <= bitCnt + 3'd1;
      if (bitCnt == 3'd7 && logCount < 64) begin
        logMem[logCount] <= {shiftIn[6:0], mosi_i};
        logCount <= logCount + 1;
      end
    end
  end

endmodule

/* tb/tbSpiMaster.sv */
`timescale 1ns/1ps

module tbSpiMaster;
  import spiPkg::*;

  localparam int NUM_FIXED = 6;
  localparam int NUM_ROWS = 12;
  localparam int MAX_DELAY = 16;
  localparam int CYCLE_LIMIT = NUM_ROWS * 20 * 16 * (MAX_DELAY + 1) + 5000;

  typedef struct packed {
    transType_t kind;
    spiByte_t   cmd;
    logic [31:0] arg;
    logic       respEn;
    spiByte_t   respIdx;
    spiByte_t   respVal;
    spiByte_t   txByte;
    spiByte_t   clkDelay;
  } row_t;

  logic clk;
  logic rst;
  regAddr_t address;
  busWord_t dataIn;
  busWord_t dataOut;
  logic select;
  logic we;
  logic spiClk;
  logic miso;
  logic mosi;
  logic csN;
  logic cardClear;
  logic cardRespEn;
  spiByte_t cardRespIdx;
  spiByte_t cardRespVal;

  row_t rows [NUM_ROWS];
  int errors;
  int checks;
  int cycles;
  time lastRise;
  int halfCycles;

  spiMaster DUT (
    .clk_i(clk), .rst_i(rst), .address_i(address), .data_i(dataIn), .data_o(dataOut),
    .select_i(select), .we_i(we), .spiClkOut_o(spiClk), .spiDataIn_i(miso),
    .spiDataOut_o(mosi), .spiCS_n_o(csN)
  );

  sdCardModel card (
    .spiClk_i(spiClk), .mosi_i(mosi), .csN_i(csN), .clear_i(cardClear),
    .respEn_i(cardRespEn), .respIdx_i(cardRespIdx), .respVal_i(cardRespVal), .miso_o(miso)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Simulation timed out after %0d cycles", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // SPI half-period in system clocks, high phase
  always @(posedge spiClk) lastRise = $time;
  always @(negedge spiClk) halfCycles = int'(($time - lastRise) / 40);

  task automatic checkByte(input string what, input spiByte_t got, input spiByte_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s got 0x%02h expected 0x%02h", $time, what, got, exp);
    end
  endtask

  task automatic checkStatus(input string what, input busWord_t got, input busWord_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s got 0x%05h expected 0x%05h", $time, what, got, exp);
    end
  endtask

  task automatic checkCount(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic busWrite(input regAddr_t addr, input busWord_t data);
    @(negedge clk);
    address = addr;
    dataIn = data;
    select = 1'b1;
    we = 1'b1;
    @(negedge clk);
    select = 1'b0;
    we = 1'b0;
  endtask

  task automatic busRead(input regAddr_t addr, output busWord_t data);
    @(negedge clk);
    address = addr;
    select = 1'b1;
    we = 1'b0;
    #1;
    data = dataOut;
  endtask

  task automatic runTransaction(input transType_t kind);
    busWord_t st;
    busWrite(REG_CTRL, busWord_t'(kind));
    st = '0;
    while (!st[0]) busRead(REG_CTRL, st);
    while (st[0]) busRead(REG_CTRL, st);
  endtask

  // Long division of the 40-bit frame by x^7 + x^3 + 1
  function automatic spiByte_t frameCrc(input spiByte_t first, input logic [31:0] arg);
    logic [46:0] rem;
    rem = {first, arg, 7'd0};
    for (int i = 46; i >= 7; i--) begin
      if (rem[i]) rem = rem ^ (47'h89 << (i - 7));
    end
    return {rem[6:0], 1'b1};
  endfunction

  task automatic applyRow(input row_t r);
    busWord_t rd;
    spiByte_t first;
    int expLog;
    cardRespEn = r.respEn;
    cardRespIdx = r.respIdx;
    cardRespVal = r.respVal;
    @(negedge clk);
    cardClear = 1'b1;
    @(negedge clk);
    cardClear = 1'b0;
    busWrite(REG_CLKDELAY, busWord_t'(r.clkDelay));
    if (r.kind == TRANS_INIT) begin
      runTransaction(TRANS_INIT);
      checkCount("init CS-high rising edges", card.csHighEdges, INIT_BYTES * 8);
      checkCount("init logged bytes", card.logCount, 0);
      checkCount("init half-period", halfCycles, int'(SLOW_SPI_CLK_DELAY) + 1);
    end else if (r.kind == TRANS_DIRECT) begin
      busWrite(REG_TXDATA, busWord_t'(r.txByte));
      runTransaction(TRANS_DIRECT);
      checkCount("direct logged bytes", card.logCount, 1);
      checkByte("direct MOSI byte", card.logMem[0], r.txByte);
      busRead(REG_RXDATA, rd);
      checkByte("direct RX byte", rd[7:0], r.respVal);
      checkCount("direct half-period", halfCycles, int'(r.clkDelay) + 1);
    end else begin
      busWrite(REG_CMD, busWord_t'(r.cmd));
      busWrite(REG_ARGHI, busWord_t'(r.arg[31:16]));
      busWrite(REG_ARGLO, busWord_t'(r.arg[15:0]));
      runTransaction(TRANS_CMD);
      first = {2'b01, r.cmd[5:0]};
      checkByte("cmd byte", card.logMem[0], first);
      for (int k = 0; k < 4; k++) begin
        checkByte("cmd arg byte", card.logMem[k + 1], r.arg[31 - 8 * k -: 8]);
      end
      checkByte("cmd CRC byte", card.logMem[5], frameCrc(first, r.arg));
      // Known CRC byte of CMD0
      if (first == 8'h40 && r.arg == 32'h0) begin
        checkByte("CMD0 CRC byte", card.logMem[5], 8'h95);
      end
      // Answer counts only inside the polling window
      if (r.respEn && r.respIdx >= 8'd6 && r.respIdx < 8'(6 + RESP_TOUT_BYTES)) begin
        expLog = int'(r.respIdx) + 1;
        busRead(REG_RESP, rd);
        checkByte("R1 response", rd[7:0], r.respVal);
        busRead(REG_CTRL, rd);
        checkStatus("status after response", rd, 18'h0);
      end else begin
        expLog = 6 + RESP_TOUT_BYTES;
        busRead(REG_RESP, rd);
        checkByte("timeout response", rd[7:0], IDLE_BYTE);
        busRead(REG_CTRL, rd);
        checkStatus("status after timeout", rd, 18'h2);
      end
      checkCount("cmd logged bytes", card.logCount, expLog);
    end
    checkByte("CS after transaction", {7'd0, csN}, 8'h01);
  endtask

  initial begin
    busWord_t rd;
    rst = 1'b1;
    address = REG_CTRL;
    dataIn = '0;
    select = 1'b0;
    we = 1'b0;
    cardClear = 1'b0;
    cardRespEn = 1'b0;
    cardRespIdx = 8'd0;
    cardRespVal = 8'hFF;
    errors = 0;
    checks = 0;
    cycles = 0;
    lastRise = 0;
    halfCycles = 0;
    void'($urandom(66679));

    rows[0] = '{TRANS_INIT, 8'h00, 32'h0, 1'b0, 8'd0, 8'hFF, 8'hFF, 8'd1};
    rows[1] = '{TRANS_DIRECT, 8'h00, 32'h0, 1'b1, 8'd0, 8'h3C, 8'hA5, 8'd1};
    rows[2] = '{TRANS_CMD, 8'h00, 32'h0, 1'b1, 8'd7, 8'h01, 8'hFF, 8'd1};
    rows[3] = '{TRANS_CMD, 8'h08, 32'h1AA, 1'b1, 8'd6, 8'h01, 8'hFF, 8'd2};
    rows[4] = '{TRANS_CMD, 8'h11, $urandom, 1'b0, 8'd0, 8'hFF, 8'hFF, 8'd0};
    rows[5] = '{TRANS_CMD, 8'h37, $urandom, 1'b1, 8'd13, 8'h00, 8'hFF, 8'd3};
    for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
      rows[i] = '{TRANS_DIRECT, 8'h00, 32'h0, 1'b1, 8'd0, spiByte_t'($urandom),
                  spiByte_t'($urandom), spiByte_t'($urandom_range(3, 0))};
    end

    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    busRead(REG_CTRL, rd);
    checkStatus("reset status", rd, 18'h0);
    checkByte("reset pins", {5'd0, csN, mosi, spiClk}, 8'h06);

    for (int i = 0; i < NUM_ROWS; i++) begin
      applyRow(rows[i]);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
source/spiPkg.sv
source/spiMasterRegs.sv
source/spiCtrl.sv
source/sendCmd.sv
source/spiTxRxData.sv
source/readWriteSPIWireData.sv
source/spiMaster.sv
tb/sdCardModel.sv
tb/tbSpiMaster.sv
